/* source/pic_pkg.sv */
// Address map, register field positions, widths and id and priority types of the interrupt controller
package pic_pkg;

   ////////////////////
   // Widths and types
   ////////////////////
   localparam int PRIO_BITS = 4;
   localparam int ID_BITS   = 8;

   typedef logic [PRIO_BITS-1:0] prio_t;
   typedef logic [ID_BITS-1:0]   id_t;

   localparam prio_t PRIO_MAX = prio_t'(15);       // Most urgent level in normal order

   ////////////////////
   // Register window
   ////////////////////
   localparam logic [31:0] PIC_BASE      = 32'hf00c_0000;

   // Offsets from PIC_BASE
   localparam logic [31:0] PRIO_OFS      = 32'h0000_0000;  // One word per source
   localparam logic [31:0] PEND_OFS      = 32'h0000_1000;  // Read only pending vector
   localparam logic [31:0] ENABLE_OFS    = 32'h0000_2000;  // One word per source
   localparam logic [31:0] CONFIG_OFS    = 32'h0000_3000;  // Single word
   localparam logic [31:0] GW_CONFIG_OFS = 32'h0000_4000;  // One word per source
   localparam logic [31:0] GW_CLEAR_OFS  = 32'h0000_5000;  // Write only, data ignored

   // Field positions
   localparam int CFG_REVERSE_BIT = 0;   // Reversed priority order
   localparam int GW_POL_BIT      = 0;   // 1 means active low
   localparam int GW_TYPE_BIT     = 1;   // 1 means latched capture

endpackage

/* source/pic_reg_port.sv */
// Register port capture, address decode, per-source and configuration registers, read data mux
`timescale 1ns/1ns

module pic_reg_port #(
   parameter int NUM_SRC = 9
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic                 picm_wren,
   input  logic                 picm_rden,
   input  logic [31:0]          picm_addr,
   input  logic [31:0]          picm_wr_data,
   input  logic [NUM_SRC-1:0]   gw_req,
   output logic [31:0]          picm_rd_data,
   output pic_pkg::prio_t       src_prio [NUM_SRC],
   output logic [NUM_SRC-1:0]   src_enable,
   output logic [NUM_SRC-1:0]   gw_polarity,
   output logic [NUM_SRC-1:0]   gw_type,
   output logic [NUM_SRC-1:0]   gw_clear,
   output logic                 reverse_order
);
   import pic_pkg::*;

   localparam int IDX_BITS = $clog2(NUM_SRC);
   localparam int WIN_LSB  = IDX_BITS + 2;     // Per-source windows are one word per id

   logic                   wren_q;
   logic                   rden_q;
   logic [31:0]            addr_q;
   logic [PRIO_BITS-1:0]   data_q;            // No field is wider than a priority

   logic                   aligned;
   logic                   prio_hit;
   logic                   enable_hit;
   logic                   gwcfg_hit;
   logic                   clear_hit;
   logic                   pend_hit;
   logic                   cfg_hit;
   logic [IDX_BITS-1:0]    src_idx;
   logic [NUM_SRC-1:0]     src_sel;

   // Per-source window match, index bits excluded
   function automatic logic in_window(input logic [31:0] addr, input logic [31:0] ofs);
      logic [31:0] base;
      base = PIC_BASE + ofs;
      return (addr >> WIN_LSB) == (base >> WIN_LSB);
   endfunction

   ////////////////////
   // Request capture
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wren_q <= 1'b0;
         rden_q <= 1'b0;
      end else begin
         wren_q <= picm_wren;
         rden_q <= picm_rden;
      end
   end

   always_ff @(posedge clk) begin
      if (picm_wren || picm_rden) begin
         addr_q <= picm_addr;
      end
      if (picm_wren) begin
         data_q <= picm_wr_data[PRIO_BITS-1:0];
      end
   end

   ////////////////////
   // Address decode
   ////////////////////
   assign aligned    = (addr_q[1:0] == 2'b00);
   assign src_idx    = addr_q[IDX_BITS+1:2];

   assign prio_hit   = aligned && in_window(addr_q, PRIO_OFS);
   assign enable_hit = aligned && in_window(addr_q, ENABLE_OFS);
   assign gwcfg_hit  = aligned && in_window(addr_q, GW_CONFIG_OFS);
   assign clear_hit  = aligned && in_window(addr_q, GW_CLEAR_OFS);
   assign pend_hit   = (addr_q == PIC_BASE + PEND_OFS);
   assign cfg_hit    = (addr_q == PIC_BASE + CONFIG_OFS);

   ////////////////////
   // Per-source registers
   ////////////////////
   for (genvar i = 0; i < NUM_SRC; i++) begin : g_src
      if (i == 0) begin : g_rsvd
         // Source 0 never requests and has no storage
         assign src_sel[i]     = 1'b0;
         assign src_prio[i]    = '0;
         assign src_enable[i]  = 1'b0;
         assign gw_polarity[i] = 1'b0;
         assign gw_type[i]     = 1'b0;
         assign gw_clear[i]    = 1'b0;
      end else begin : g_reg
         assign src_sel[i] = (src_idx == IDX_BITS'(i));

         always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
               src_prio[i]    <= '0;
               src_enable[i]  <= 1'b0;
               gw_polarity[i] <= 1'b0;
               gw_type[i]     <= 1'b0;
               gw_clear[i]    <= 1'b0;
            end else begin
               gw_clear[i] <= wren_q && clear_hit && src_sel[i];   // One cycle pulse
               if (wren_q && src_sel[i]) begin
                  if (prio_hit) begin
                     src_prio[i] <= data_q;
                  end
                  if (enable_hit) begin
                     src_enable[i] <= data_q[0];
                  end
                  if (gwcfg_hit) begin
                     gw_polarity[i] <= data_q[GW_POL_BIT];
                     gw_type[i]     <= data_q[GW_TYPE_BIT];
                  end
               end
            end
         end
      end
   end

   // Configuration word
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         reverse_order <= 1'b0;
      end else if (wren_q && cfg_hit) begin
         reverse_order <= data_q[CFG_REVERSE_BIT];
      end
   end

   ////////////////////
   // Read data
   ////////////////////
   always_comb begin
      picm_rd_data = '0;
      if (rden_q) begin
         if (pend_hit) begin
            picm_rd_data |= 32'(gw_req);
         end
         if (cfg_hit) begin
            picm_rd_data[CFG_REVERSE_BIT] |= reverse_order;
         end
         for (int i = 0; i < NUM_SRC; i++) begin
            if (src_sel[i]) begin
               if (prio_hit) begin
                  picm_rd_data |= 32'(src_prio[i]);
               end
               if (enable_hit) begin
                  picm_rd_data[0] |= src_enable[i];
               end
               if (gwcfg_hit) begin
                  picm_rd_data[GW_POL_BIT]  |= gw_polarity[i];
                  picm_rd_data[GW_TYPE_BIT] |= gw_type[i];
               end
            end
         end
      end
   end

endmodule

/* source/pic_gateway.sv */
// Two-flop request synchronizer and level or latched gateway for one interrupt source
`timescale 1ns/1ns

module pic_gateway (
   input  logic clk,
   input  logic rst_n,
   input  logic req_raw,       // Asynchronous request line
   input  logic polarity,      // 1 means active low
   input  logic latch_mode,    // 1 means latched capture
   input  logic clear,         // Clears the latch
   output logic req
);

   logic sync_q1;
   logic sync_q2;
   logic active;
   logic pend_q;
   logic pend_nxt;

   ////////////////////
   // Synchronizer
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sync_q1 <= 1'b0;
         sync_q2 <= 1'b0;
      end else begin
         sync_q1 <= req_raw;
         sync_q2 <= sync_q1;
      end
   end

   assign active = sync_q2 ^ polarity;

   ////////////////////
   // Latch
   ////////////////////
   // An active input wins over a clear in the same cycle
   assign pend_nxt = latch_mode && (active || (pend_q && !clear));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pend_q <= 1'b0;
      end else begin
         pend_q <= pend_nxt;
      end
   end

   assign req = latch_mode ? (active | pend_q) : active;

endmodule

/* source/pic_priority_tree.sv */
// Combinational pairwise comparison tree that picks the winning source id and priority
`timescale 1ns/1ns

module pic_priority_tree #(
   parameter int NUM_SRC = 9
) (
   input  pic_pkg::prio_t masked_prio [NUM_SRC],
   output pic_pkg::id_t   win_id,
   output pic_pkg::prio_t win_prio
);
   import pic_pkg::*;

   localparam int LEVELS = $clog2(NUM_SRC);
   localparam int WIDTH  = NUM_SRC + 1;    // Room for one pad entry

   prio_t lvl_prio [LEVELS+1][WIDTH];
   id_t   lvl_id   [LEVELS+1][WIDTH];

   // Number of live entries at a level
   function automatic int level_cnt(input int lvl);
      int cnt;
      cnt = NUM_SRC;
      for (int k = 0; k < lvl; k++) begin
         cnt = (cnt + 1) / 2;
      end
      return cnt;
   endfunction

   // Left entry is kept unless the right one is strictly more urgent
   function automatic logic [ID_BITS+PRIO_BITS-1:0] pick(
      input id_t   a_id,
      input prio_t a_prio,
      input id_t   b_id,
      input prio_t b_prio
   );
      if (b_prio > a_prio) begin
         return {b_id, b_prio};
      end
      return {a_id, a_prio};
   endfunction

   ////////////////////
   // Tree levels
   ////////////////////
   for (genvar l = 0; l <= LEVELS; l++) begin : g_lvl
      for (genvar m = 0; m < WIDTH; m++) begin : g_node
         if (m >= level_cnt(l)) begin : g_pad
            // Zero priority pad on odd levels, never beats a left entry
            assign lvl_prio[l][m] = '0;
            assign lvl_id[l][m]   = '0;
         end else if (l == 0) begin : g_leaf
            assign lvl_prio[l][m] = masked_prio[m];
            assign lvl_id[l][m]   = id_t'(m);
         end else begin : g_cmp
            assign {lvl_id[l][m], lvl_prio[l][m]} = pick(lvl_id[l-1][2*m],
                                                         lvl_prio[l-1][2*m],
                                                         lvl_id[l-1][2*m+1],
                                                         lvl_prio[l-1][2*m+1]);
         end
      end
   end

   assign win_id   = lvl_id[LEVELS][0];     // Id 0 when nothing is pending
   assign win_prio = lvl_prio[LEVELS][0];

endmodule

/* source/pic_notify.sv */
// Claim id and level registers with threshold compare and wake-up detection
`timescale 1ns/1ns

module pic_notify (
   input  logic           clk,
   input  logic           rst_n,
   input  pic_pkg::id_t   win_id,
   input  pic_pkg::prio_t win_prio,        // In normal order, higher is more urgent
   input  logic           reverse_order,
   input  pic_pkg::prio_t meipt,           // Priority threshold
   input  pic_pkg::prio_t meicurpl,        // Current level of the core
   output pic_pkg::id_t   claimid,
   output pic_pkg::prio_t pl,
   output logic           mexintpend,
   output logic           mhwakeup
);
   import pic_pkg::*;

   prio_t thresh_eff;
   prio_t curpl_eff;
   prio_t pl_nxt;
   prio_t wake_lvl;
   logic  notify_nxt;
   logic  wake_nxt;

   ////////////////////
   // Compare
   ////////////////////
   // Bring threshold and current level into the tree's ordering
   assign thresh_eff = reverse_order ? ~meipt    : meipt;
   assign curpl_eff  = reverse_order ? ~meicurpl : meicurpl;

   assign notify_nxt = (win_prio > thresh_eff) && (win_prio > curpl_eff);

   assign pl_nxt   = reverse_order ? ~win_prio : win_prio;   // Back to the source's own number
   assign wake_lvl = reverse_order ? '0 : PRIO_MAX;
   assign wake_nxt = (pl_nxt == wake_lvl);

   ////////////////////
   // Output registers
   ////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         claimid    <= '0;
         pl         <= '0;
         mexintpend <= 1'b0;
         mhwakeup   <= 1'b0;
      end else begin
         claimid    <= win_id;
         pl         <= pl_nxt;
         mexintpend <= notify_nxt;
         mhwakeup   <= wake_nxt;
      end
   end

endmodule

/* source/pic_ctrl.sv */
// Interrupt controller top level with register port, gateway array, priority tree and outputs
`timescale 1ns/1ns

module pic_ctrl #(
   parameter int NUM_SRC = 9              // 2 to 16, source 0 reserved
) (
   input  logic                 clk,
   input  logic                 rst_n,
   input  logic [NUM_SRC-1:0]   extintsrc_req,
   input  logic                 picm_wren,
   input  logic                 picm_rden,
   input  logic [31:0]          picm_addr,
   input  logic [31:0]          picm_wr_data,
   input  pic_pkg::prio_t       meipt,
   input  pic_pkg::prio_t       meicurpl,
   output logic [31:0]          picm_rd_data,
   output pic_pkg::id_t         claimid,
   output pic_pkg::prio_t       pl,
   output logic                 mexintpend,
   output logic                 mhwakeup
);
   import pic_pkg::*;

   prio_t              src_prio    [NUM_SRC];
   prio_t              masked_prio [NUM_SRC];
   logic [NUM_SRC-1:0] src_enable;
   logic [NUM_SRC-1:0] gw_polarity;
   logic [NUM_SRC-1:0] gw_type;
   logic [NUM_SRC-1:0] gw_clear;
   logic [NUM_SRC-1:0] gw_req;
   logic               reverse_order;
   id_t                win_id;
   prio_t              win_prio;

   pic_reg_port #(.NUM_SRC(NUM_SRC)) u_reg_port (
      .clk           (clk),
      .rst_n         (rst_n),
      .picm_wren     (picm_wren),
      .picm_rden     (picm_rden),
      .picm_addr     (picm_addr),
      .picm_wr_data  (picm_wr_data),
      .gw_req        (gw_req),
      .picm_rd_data  (picm_rd_data),
      .src_prio      (src_prio),
      .src_enable    (src_enable),
      .gw_polarity   (gw_polarity),
      .gw_type       (gw_type),
      .gw_clear      (gw_clear),
      .reverse_order (reverse_order)
   );

   ////////////////////
   // Gateways
   ////////////////////
   assign gw_req[0] = 1'b0;   // Reserved source

   for (genvar i = 1; i < NUM_SRC; i++) begin : g_gw
      pic_gateway u_gw (
         .clk        (clk),
         .rst_n      (rst_n),
         .req_raw    (extintsrc_req[i]),
         .polarity   (gw_polarity[i]),
         .latch_mode (gw_type[i]),
         .clear      (gw_clear[i]),
         .req        (gw_req[i])
      );
   end

   // Pending and enabled sources only, inverted for reversed order
   for (genvar i = 0; i < NUM_SRC; i++) begin : g_mask
      assign masked_prio[i] = {PRIO_BITS{gw_req[i] & src_enable[i]}}
                            & (reverse_order ? ~src_prio[i] : src_prio[i]);
   end

   pic_priority_tree #(.NUM_SRC(NUM_SRC)) u_tree (
      .masked_prio (masked_prio),
      .win_id      (win_id),
      .win_prio    (win_prio)
   );

   pic_notify u_notify (
      .clk           (clk),
      .rst_n         (rst_n),
      .win_id        (win_id),
      .win_prio      (win_prio),
      .reverse_order (reverse_order),
      .meipt         (meipt),
      .meicurpl      (meicurpl),
      .claimid       (claimid),
      .pl            (pl),
      .mexintpend    (mexintpend),
      .mhwakeup      (mhwakeup)
   );

endmodule

/* dv/pic_ctrl_tb.sv */
// Testbench for the interrupt controller with shadow registers, reference model, compare process and watchdog
`timescale 1ns/1ns

module pic_ctrl_tb;
   import pic_pkg::*;

   localparam int NUM_SRC     = 9;
   localparam int N_ITER      = 40;                         // Random iterations per order
   localparam int ITER_CYC    = 100;                        // Upper bound of cycles per iteration
   localparam int WATCHDOG_NS = (2 * N_ITER * ITER_CYC + 1000) * 20;

   logic               clk;
   logic               rst_n;
   logic [NUM_SRC-1:0] extintsrc_req;
   logic               picm_wren;
   logic               picm_rden;
   logic [31:0]        picm_addr;
   logic [31:0]        picm_wr_data;
   prio_t              meipt;
   prio_t              meicurpl;
   logic [31:0]        picm_rd_data;
   id_t                claimid;
   prio_t              pl;
   logic               mexintpend;
   logic               mhwakeup;

   // Shadow copy of the register state and of the gateway latches
   prio_t              prio_sh [NUM_SRC];
   logic [NUM_SRC-1:0] en_sh;
   logic [NUM_SRC-1:0] pol_sh;
   logic [NUM_SRC-1:0] typ_sh;
   logic [NUM_SRC-1:0] latch_sh;
   logic               rev_sh;

   integer seed;
   int     err_cnt;
   int     chk_cnt;
   event   stim_done;
   event   cmp_done;

   pic_ctrl #(.NUM_SRC(NUM_SRC)) uut (
      .clk           (clk),
      .rst_n         (rst_n),
      .extintsrc_req (extintsrc_req),
      .picm_wren     (picm_wren),
      .picm_rden     (picm_rden),
      .picm_addr     (picm_addr),
      .picm_wr_data  (picm_wr_data),
      .meipt         (meipt),
      .meicurpl      (meicurpl),
      .picm_rd_data  (picm_rd_data),
      .claimid       (claimid),
      .pl            (pl),
      .mexintpend    (mexintpend),
      .mhwakeup      (mhwakeup)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("** Error at %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      end
   endtask

   ////////////////////
   // Reference model
   ////////////////////
   function automatic logic [NUM_SRC-1:0] expect_pend();
      logic [NUM_SRC-1:0] p;
      logic               act;
      p = '0;
      for (int i = 1; i < NUM_SRC; i++) begin
         act  = extintsrc_req[i] ^ pol_sh[i];           // Polarity 1 is active low
         p[i] = typ_sh[i] ? (act | latch_sh[i]) : act;
      end
      return p;
   endfunction

   // Returns claimid, pl, mexintpend and mhwakeup packed in that order
   function automatic logic [13:0] expect_out();
      logic [NUM_SRC-1:0] p;
      int                 urg;
      int                 best;
      int                 best_id;
      int                 thr;
      int                 cur;
      int                 lvl;
      p       = expect_pend();
      best    = 0;
      best_id = 0;
      for (int i = 1; i < NUM_SRC; i++) begin
         urg = rev_sh ? 15 - int'(prio_sh[i]) : int'(prio_sh[i]);
         if (p[i] && en_sh[i] && urg > best) begin   // Lower id kept on a tie
            best    = urg;
            best_id = i;
         end
      end
      thr = rev_sh ? 15 - int'(meipt) : int'(meipt);
      cur = rev_sh ? 15 - int'(meicurpl) : int'(meicurpl);
      lvl = rev_sh ? 15 - best : best;
      return {8'(best_id), 4'(lvl), (best > thr) && (best > cur), lvl == (rev_sh ? 0 : 15)};
   endfunction

   ////////////////////
   // Register access
   ////////////////////
   task automatic reg_write(input logic [31:0] addr, input logic [31:0] data);
      @(negedge clk);
      picm_wren    = 1'b1;
      picm_addr    = addr;
      picm_wr_data = data;
      @(negedge clk);
      picm_wren    = 1'b0;
   endtask

   task automatic reg_read(input logic [31:0] addr, output logic [31:0] data);
      @(negedge clk);
      picm_rden = 1'b1;
      picm_addr = addr;
      @(negedge clk);
      data      = picm_rd_data;                        // Valid in the cycle after capture
      picm_rden = 1'b0;
   endtask

   // Per-source write that keeps the shadow copy in step
   task automatic src_write(input logic [31:0] ofs, input int i, input logic [31:0] data);
      reg_write(PIC_BASE + ofs + 32'(4 * i), data);
      if (i != 0) begin
         case (ofs)
            PRIO_OFS:   prio_sh[i] = data[3:0];
            ENABLE_OFS: en_sh[i] = data[0];
            GW_CONFIG_OFS: begin
               pol_sh[i]   = data[0];
               typ_sh[i]   = data[1];
               latch_sh[i] = typ_sh[i] & (latch_sh[i] | (extintsrc_req[i] ^ pol_sh[i]));
            end
            GW_CLEAR_OFS: latch_sh[i] = typ_sh[i] & (extintsrc_req[i] ^ pol_sh[i]);
            default: ;
         endcase
      end
   endtask

   task automatic config_write(input logic [31:0] data);
      reg_write(PIC_BASE + CONFIG_OFS, data);
      rev_sh = data[0];
   endtask

   task automatic apply_and_compare(input logic [NUM_SRC-1:0] lvl, input prio_t thr,
                                    input prio_t cur);
      @(negedge clk);
      extintsrc_req = lvl;
      meipt         = thr;
      meicurpl      = cur;
      latch_sh      = latch_sh | (typ_sh & (lvl ^ pol_sh));
      -> stim_done;
      @(cmp_done);
   endtask

   task automatic check_pending();
      logic [31:0] rd;
      reg_read(PIC_BASE + PEND_OFS, rd);
      check("pending vector", rd, 32'(expect_pend()));
   endtask

   // Outputs settle within 4 edges of any stimulus change
   initial begin : compare_proc
      logic [13:0] exp;
      forever begin
         @(stim_done);
         repeat (4) @(posedge clk);
         @(negedge clk);
         exp = expect_out();
         check("claimid", 32'(claimid), 32'(exp[13:6]));
         check("pl", 32'(pl), 32'(exp[5:2]));
         check("mexintpend", 32'(mexintpend), 32'(exp[1]));
         check("mhwakeup", 32'(mhwakeup), 32'(exp[0]));
         -> cmp_done;
      end
   end

   ////////////////////
   // Tests
   ////////////////////
   task automatic readback_test();
      logic [31:0] rd;
      for (int i = 0; i < NUM_SRC; i++) begin
         src_write(PRIO_OFS, i, $random(seed));
         reg_read(PIC_BASE + PRIO_OFS + 32'(4 * i), rd);
         check("priority readback", rd, 32'(prio_sh[i]));
         src_write(ENABLE_OFS, i, $random(seed));
         reg_read(PIC_BASE + ENABLE_OFS + 32'(4 * i), rd);
         check("enable readback", rd, 32'(en_sh[i]));
         src_write(GW_CONFIG_OFS, i, $random(seed));
         reg_read(PIC_BASE + GW_CONFIG_OFS + 32'(4 * i), rd);
         check("gateway readback", rd, 32'({typ_sh[i], pol_sh[i]}));
      end
      config_write($random(seed) | 1);
      reg_read(PIC_BASE + CONFIG_OFS, rd);
      check("config readback", rd, 32'(rev_sh));
      reg_read(PIC_BASE + PRIO_OFS + 32'(4 * 12), rd);  // No source 12
      check("unmapped source read", rd, 32'h0);
      reg_read(PIC_BASE + 32'h6000, rd);
      check("unmapped address read", rd, 32'h0);
      config_write(32'h0);
      for (int i = 1; i < NUM_SRC; i++) begin
         src_write(GW_CONFIG_OFS, i, 32'h0);
      end
   endtask

   // Level capture with random polarity
   task automatic random_arbitration(input logic rev);
      for (int n = 0; n < N_ITER; n++) begin
         config_write(32'(rev));
         for (int i = 1; i < NUM_SRC; i++) begin
            src_write(PRIO_OFS, i, $random(seed));
            src_write(ENABLE_OFS, i, $random(seed));
            src_write(GW_CONFIG_OFS, i, $random(seed) & 32'h1);
         end
         apply_and_compare(NUM_SRC'($random(seed)), prio_t'($random(seed)),
                           prio_t'($random(seed)));
         check_pending();
      end
   endtask

   task automatic latched_test();
      for (int i = 1; i < NUM_SRC; i++) begin
         src_write(ENABLE_OFS, i, 32'(i == 3));
      end
      src_write(PRIO_OFS, 3, 32'd9);
      src_write(GW_CONFIG_OFS, 3, 32'h2);
      apply_and_compare(NUM_SRC'(8), 4'd0, 4'd0);      // Pulse on source 3
      apply_and_compare('0, 4'd0, 4'd0);
      check("latched claimid", 32'(claimid), 32'd3);
      check_pending();
      src_write(GW_CLEAR_OFS, 3, $random(seed));
      apply_and_compare('0, 4'd0, 4'd0);
      check("cleared claimid", 32'(claimid), 32'd0);
      check_pending();
      apply_and_compare(NUM_SRC'(8), 4'd0, 4'd0);
      src_write(GW_CLEAR_OFS, 3, $random(seed));      // Clear while still active
      apply_and_compare('0, 4'd0, 4'd0);
      check_pending();
      src_write(GW_CLEAR_OFS, 3, 32'h0);
   endtask

   task automatic polarity_test();
      for (int i = 1; i < NUM_SRC; i++) begin
         src_write(ENABLE_OFS, i, 32'(i == 5));
      end
      src_write(PRIO_OFS, 5, 32'd12);
      src_write(GW_CONFIG_OFS, 5, 32'h1);
      apply_and_compare('0, 4'd3, 4'd3);
      check("active low claimid", 32'(claimid), 32'd5);
      check_pending();
      apply_and_compare(NUM_SRC'(32), 4'd3, 4'd3);
      check("inactive claimid", 32'(claimid), 32'd0);
      check_pending();
   endtask

   task automatic reversed_wake_test();
      config_write(32'h1);
      for (int i = 1; i < NUM_SRC; i++) begin
         src_write(ENABLE_OFS, i, 32'(i == 2));
         src_write(GW_CONFIG_OFS, i, 32'h0);
      end
      src_write(PRIO_OFS, 2, 32'd0);
      apply_and_compare(NUM_SRC'(4), 4'hf, 4'hf);
      check("reversed claimid", 32'(claimid), 32'd2);
      check("reversed wakeup", 32'(mhwakeup), 32'd1);
   endtask

   initial begin : main_proc
      seed          = 44283;
      err_cnt       = 0;
      chk_cnt       = 0;
      rst_n         = 1'b0;
      extintsrc_req = '0;
      picm_wren     = 1'b0;
      picm_rden     = 1'b0;
      picm_addr     = '0;
      picm_wr_data  = '0;
      meipt         = '0;
      meicurpl      = '0;
      en_sh         = '0;
      pol_sh        = '0;
      typ_sh        = '0;
      latch_sh      = '0;
      rev_sh        = 1'b0;
      for (int i = 0; i < NUM_SRC; i++) begin
         prio_sh[i] = '0;
      end
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      check("reset claimid", 32'(claimid), 32'h0);
      check("reset pl", 32'(pl), 32'h0);
      check("reset mexintpend", 32'(mexintpend), 32'h0);
      check("reset mhwakeup", 32'(mhwakeup), 32'h0);
      check("reset read data", picm_rd_data, 32'h0);
      check_pending();

      readback_test();
      random_arbitration(1'b0);
      latched_test();
      polarity_test();
      random_arbitration(1'b1);
      reversed_wake_test();

      $display("Checks run: %0d, errors: %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

   initial begin : watchdog_proc
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display(">>> FAIL");
      $finish;
   end

endmodule

/* pic_ctrl.f */
source/pic_pkg.sv
source/pic_reg_port.sv
source/pic_gateway.sv
source/pic_priority_tree.sv
source/pic_notify.sv
source/pic_ctrl.sv
dv/pic_ctrl_tb.sv

/* Makefile */
# Verilator simulation of the interrupt controller testbench

VERILATOR ?= verilator
TOP       ?= pic_ctrl_tb
FILELIST  ?= pic_ctrl.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

# The run passes only if the pass message appears on a line of its own
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
